/* tb.f */
+incdir+verif
rtl/periph_pkg.sv
rtl/periph_addr_decode.sv
rtl/periph_timer.sv
rtl/periph_result_merge.sv
rtl/periph_top.sv
verif/tb_periph_top.sv

/* verif/tb_periph_model.svh */
`ifndef TB_PERIPH_MODEL_SVH
`define TB_PERIPH_MODEL_SVH

// reference state, one entry per timer
logic        m_en    [NUM_TIMERS];
logic        m_ie    [NUM_TIMERS];
logic        m_ip    [NUM_TIMERS];
logic [31:0] m_count [NUM_TIMERS];
logic [31:0] m_value [NUM_TIMERS];

// fibonacci lfsr state
logic [31:0] lfsr_q;

function automatic void model_reset();
    for (int t = 0; t < NUM_TIMERS; t++) begin
        m_en[t]    = 1'b0;
        m_ie[t]    = 1'b0;
        m_ip[t]    = 1'b0;
        m_count[t] = '0;
        m_value[t] = '0;
    end
endfunction

// one rising edge, with the bus inputs present at that edge
function automatic void model_step(input logic [ADDR_W-1:0] addr,
                                   input logic [DATA_W-1:0] data,
                                   input logic              we);
    int         slot;
    logic [3:0] off;
    logic       hit;
    logic       expire;
    slot = int'(addr[SLOT_LSB +: SLOT_W]);
    off  = addr[3:0];
    for (int t = 0; t < NUM_TIMERS; t++) begin
        hit    = we && (slot == t);
        expire = m_en[t] && (m_count[t] >= m_value[t]);
        if (m_en[t] && !expire) begin
            m_count[t] = m_count[t] + 1;
        end else begin
            m_count[t] = '0;
        end
        if (hit && (off == REG_VALUE)) begin
            m_value[t] = data;
        end
        // a write into this slot holds off the expiry update
        if (hit) begin
            if (off == REG_CTRL) begin
                m_en[t] = data[CTRL_EN];
                m_ie[t] = data[CTRL_IE];
                if (data[CTRL_IP]) begin
                    m_ip[t] = 1'b0;
                end
            end
        end else if (expire) begin
            m_en[t] = 1'b0;
            m_ip[t] = 1'b1;
        end
    end
endfunction

function automatic logic [DATA_W-1:0] exp_data(input logic [ADDR_W-1:0] addr);
    int          slot;
    logic [3:0]  off;
    logic [31:0] word;
    slot = int'(addr[SLOT_LSB +: SLOT_W]);
    off  = addr[3:0];
    word = '0;
    if (slot < NUM_TIMERS) begin
        if (off == REG_CTRL) begin
            word[CTRL_EN] = m_en[slot];
            word[CTRL_IE] = m_ie[slot];
            word[CTRL_IP] = m_ip[slot];
        end else if (off == REG_COUNT) begin
            word = m_count[slot];
        end else if (off == REG_VALUE) begin
            word = m_value[slot];
        end
    end
    return word;
endfunction

function automatic logic exp_addr_err(input logic [ADDR_W-1:0] addr);
    int         slot;
    logic [3:0] off;
    slot = int'(addr[SLOT_LSB +: SLOT_W]);
    off  = addr[3:0];
    return (slot >= NUM_TIMERS) ||
           !((off == REG_CTRL) || (off == REG_COUNT) || (off == REG_VALUE));
endfunction

function automatic logic exp_irq();
    logic any;
    any = 1'b0;
    for (int t = 0; t < NUM_TIMERS; t++) begin
        any = any | (m_ip[t] & m_ie[t]);
    end
    return any;
endfunction

// lowest pending line wins
function automatic logic [TIMER_ID_W-1:0] exp_irq_id();
    logic [TIMER_ID_W-1:0] id;
    id = '0;
    for (int t = NUM_TIMERS - 1; t >= 0; t--) begin
        if (m_ip[t] && m_ie[t]) begin
            id = TIMER_ID_W'(t);
        end
    end
    return id;
endfunction

// taps 32, 22, 2, 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        r      = {r[30:0], fb};
    end
    return r;
endfunction

`endif

/* verif/tb_periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_periph_top;
    import periph_pkg::*;

    localparam logic [31:0] LFSR_SEED   = 32'h635a_63ca;
    localparam int          CYCLE_LIMIT = 6000;
    localparam int          EXPIRY_RUNS = 12;
    localparam int          RW_LOOPS    = 8;
    localparam int          BAD_LOOPS   = 12;

    // control words
    localparam logic [31:0] CTRL_RUN     = 32'd1 << CTRL_EN;
    localparam logic [31:0] CTRL_IE_ONLY = 32'd1 << CTRL_IE;
    localparam logic [31:0] CTRL_RUN_IRQ = CTRL_RUN | CTRL_IE_ONLY;
    localparam logic [31:0] CTRL_CLEAR   = 32'd1 << CTRL_IP;

    logic                  clk;
    logic                  rst_n_i;
    logic [ADDR_W-1:0]     addr_i;
    logic [DATA_W-1:0]     data_i;
    logic                  we_i;
    logic [DATA_W-1:0]     data_o;
    logic                  irq_o;
    logic [TIMER_ID_W-1:0] irq_id_o;
    logic                  addr_err_o;
    int                    cycle_cnt = 0;

    `include "tb_periph_model.svh"

    periph_top u_dut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .addr_i     (addr_i),
        .data_i     (data_i),
        .we_i       (we_i),
        .data_o     (data_o),
        .irq_o      (irq_o),
        .irq_id_o   (irq_id_o),
        .addr_err_o (addr_err_o)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("ERR %0t %s expected %h got %h", $time, name, exp_v, act_v);
        abort_run("output differs from the reference model");
    endtask

    // model follows every rising edge out of reset
    always @(posedge clk) begin
        if (rst_n_i) begin
            model_step(addr_i, data_i, we_i);
        end
    end

    // outputs are stable here, new inputs land after these reads
    always @(negedge clk) begin
        assert (data_o === exp_data(addr_i))
            else report_mismatch("data_o", exp_data(addr_i), data_o);
        assert (irq_o === exp_irq())
            else report_mismatch("irq_o", exp_irq(), irq_o);
        assert (irq_id_o === exp_irq_id())
            else report_mismatch("irq_id_o", exp_irq_id(), irq_id_o);
        assert (addr_err_o === exp_addr_err(addr_i))
            else report_mismatch("addr_err_o", exp_addr_err(addr_i), addr_err_o);
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, still running after %0d cycles", cycle_cnt));
        end
    end

    function automatic logic [ADDR_W-1:0] reg_addr(input int t, input logic [3:0] off);
        return (ADDR_W'(t) << SLOT_LSB) | ADDR_W'(off);
    endfunction

    task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(negedge clk);
        addr_i <= a;
        data_i <= d;
        we_i   <= 1'b1;
    endtask

    task automatic set_addr(input logic [ADDR_W-1:0] a);
        @(negedge clk);
        addr_i <= a;
        we_i   <= 1'b0;
    endtask

    task automatic bus_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            we_i <= 1'b0;
        end
    endtask

    task automatic read_all_regs();
        for (int t = 0; t < NUM_TIMERS; t++) begin
            set_addr(reg_addr(t, REG_CTRL));
            set_addr(reg_addr(t, REG_COUNT));
            set_addr(reg_addr(t, REG_VALUE));
        end
        bus_idle(1);
    endtask

    task automatic check_register_access();
        int         slot;
        logic [3:0] off;
        for (int t = 0; t < NUM_TIMERS; t++) begin
            for (int i = 0; i < RW_LOOPS; i++) begin
                bus_write(reg_addr(t, REG_VALUE), rand_bits(32));
                set_addr(reg_addr(t, REG_VALUE));
                bus_write(reg_addr(t, REG_CTRL), rand_bits(32));
                set_addr(reg_addr(t, REG_CTRL));
                bus_write(reg_addr(t, REG_COUNT), rand_bits(32));
                set_addr(reg_addr(t, REG_COUNT));
            end
            bus_write(reg_addr(t, REG_CTRL), CTRL_CLEAR);
            set_addr(reg_addr(t, REG_CTRL));
        end
        // unmapped slots, then holes inside mapped slots
        for (int i = 0; i < BAD_LOOPS; i++) begin
            if (i % 2 == 0) begin
                slot = NUM_TIMERS + int'(rand_bits(3));
                off  = 4'(rand_bits(4));
            end else begin
                slot = int'(rand_bits(1));
                off  = 4'(rand_bits(4));
                if ((off == REG_CTRL) || (off == REG_COUNT) || (off == REG_VALUE)) begin
                    off = 4'hc;
                end
            end
            bus_write(reg_addr(slot, off), rand_bits(32));
            set_addr(reg_addr(slot, off));
        end
        read_all_regs();
    endtask

    task automatic run_expiry(input int t, input logic [31:0] v);
        int elapsed;
        bus_write(reg_addr(t, REG_VALUE), v);
        bus_write(reg_addr(t, REG_CTRL), CTRL_RUN_IRQ);
        elapsed = 0;
        set_addr(reg_addr(t, REG_COUNT));
        while (!irq_o && (elapsed < 300)) begin
            set_addr(reg_addr(t, REG_COUNT));
            elapsed++;
        end
        assert (elapsed == v + 1)
            else abort_run($sformatf("timer %0d expired after %0d edges, expected %0d",
                                     t, elapsed, v + 1));
        // count must sit at zero once stopped
        bus_idle(2);
        set_addr(reg_addr(t, REG_CTRL));
        bus_write(reg_addr(t, REG_CTRL), CTRL_CLEAR);
        set_addr(reg_addr(t, REG_CTRL));
    endtask

    task automatic check_irq_control(input int t);
        bus_write(reg_addr(t, REG_VALUE), rand_bits(8));
        bus_write(reg_addr(t, REG_CTRL), CTRL_RUN);
        set_addr(reg_addr(t, REG_CTRL));
        while (!m_ip[t]) begin
            set_addr(reg_addr(t, REG_CTRL));
        end
        assert (irq_o === 1'b0) else report_mismatch("irq_o", 0, irq_o);
        bus_write(reg_addr(t, REG_CTRL), CTRL_IE_ONLY);
        set_addr(reg_addr(t, REG_CTRL));
        assert (irq_o === 1'b1) else report_mismatch("irq_o", 1, irq_o);
        bus_write(reg_addr(t, REG_CTRL), CTRL_IE_ONLY);
        set_addr(reg_addr(t, REG_CTRL));
        assert (irq_o === 1'b1) else report_mismatch("irq_o", 1, irq_o);
        bus_write(reg_addr(t, REG_CTRL), CTRL_IE_ONLY | CTRL_CLEAR);
        set_addr(reg_addr(t, REG_CTRL));
        assert (irq_o === 1'b0) else report_mismatch("irq_o", 0, irq_o);
    endtask

    task automatic check_two_timers();
        logic [31:0] v0;
        logic [31:0] v1;
        v1 = rand_bits(8);
        v0 = rand_bits(8);
        if (v0 == v1) begin
            v0 = v0 ^ 32'h1;
        end
        bus_write(reg_addr(1, REG_VALUE), v1);
        bus_write(reg_addr(1, REG_CTRL), CTRL_RUN_IRQ);
        // traffic to timer 0 while timer 1 runs
        for (int i = 0; i < 4; i++) begin
            bus_write(reg_addr(0, REG_VALUE), rand_bits(32));
            set_addr(reg_addr(1, REG_COUNT));
        end
        bus_write(reg_addr(0, REG_VALUE), v0);
        bus_write(reg_addr(0, REG_CTRL), CTRL_RUN_IRQ);
        while (!(m_ip[0] && m_ip[1])) begin
            set_addr(reg_addr(0, REG_COUNT));
            set_addr(reg_addr(1, REG_COUNT));
        end
        assert (irq_id_o === 1'b0) else report_mismatch("irq_id_o", 0, irq_id_o);
        bus_write(reg_addr(0, REG_CTRL), CTRL_CLEAR);
        set_addr(reg_addr(0, REG_CTRL));
        assert (irq_id_o === 1'b1) else report_mismatch("irq_id_o", 1, irq_id_o);
        bus_write(reg_addr(1, REG_CTRL), CTRL_CLEAR);
        set_addr(reg_addr(1, REG_CTRL));
        assert (irq_o === 1'b0) else report_mismatch("irq_o", 0, irq_o);
    endtask

    // control writes land exactly on the expiry edges
    task automatic check_write_at_expiry(input int t);
        logic [31:0] v;
        v = rand_bits(6);
        bus_write(reg_addr(t, REG_VALUE), v);
        bus_write(reg_addr(t, REG_CTRL), CTRL_RUN_IRQ);
        bus_idle(v);
        bus_write(reg_addr(t, REG_CTRL), CTRL_RUN_IRQ);
        bus_idle(v);
        bus_write(reg_addr(t, REG_CTRL), '0);
        set_addr(reg_addr(t, REG_CTRL));
        assert (data_o === '0) else report_mismatch("data_o", 0, data_o);
        set_addr(reg_addr(t, REG_COUNT));
        bus_idle(2);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n_i = 1'b0;
        addr_i  = '0;
        data_i  = '0;
        we_i    = 1'b0;
        lfsr_q  = LFSR_SEED;
        model_reset();
        repeat (4) @(negedge clk);
        rst_n_i <= 1'b1;
        read_all_regs();
        check_register_access();
        for (int i = 0; i < EXPIRY_RUNS; i++) begin
            run_expiry(i % NUM_TIMERS, rand_bits(8));
        end
        check_irq_control(1);
        check_two_timers();
        check_write_at_expiry(0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_top (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire [periph_pkg::ADDR_W-1:0]     addr_i,
    input  wire [periph_pkg::DATA_W-1:0]     data_i,
    input  wire                              we_i,
    output logic [periph_pkg::DATA_W-1:0]    data_o,
    output logic                             irq_o,
    output logic [periph_pkg::TIMER_ID_W-1:0] irq_id_o,
    output logic                             addr_err_o
);
    import periph_pkg::*;

    logic [NUM_TIMERS-1:0]             sel;
    logic [NUM_TIMERS-1:0]             timer_we;
    logic [NUM_TIMERS-1:0][DATA_W-1:0] rd_data;
    logic [NUM_TIMERS-1:0]             irq;

    // decode
    periph_addr_decode u_decode (
        .addr_i     (addr_i),
        .we_i       (we_i),
        .sel_o      (sel),
        .timer_we_o (timer_we),
        .addr_err_o (addr_err_o)
    );

    // execute, one timer per mapped slot
    for (genvar g = 0; g < NUM_TIMERS; g++) begin : g_timer
        periph_timer u_timer (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .we_i      (timer_we[g]),
            .offset_i  (addr_i[SLOT_LSB-1:0]),
            .data_i    (data_i),
            .rd_data_o (rd_data[g]),
            .irq_o     (irq[g])
        );
    end

    // result
    periph_result_merge u_merge (
        .sel_i     (sel),
        .rd_data_i (rd_data),
        .irq_i     (irq),
        .data_o    (data_o),
        .irq_o     (irq_o),
        .irq_id_o  (irq_id_o)
    );

endmodule

`default_nettype wire

/* rtl/periph_result_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_result_merge (
    input  wire [periph_pkg::NUM_TIMERS-1:0]                        sel_i,
    input  wire [periph_pkg::NUM_TIMERS-1:0][periph_pkg::DATA_W-1:0] rd_data_i,
    input  wire [periph_pkg::NUM_TIMERS-1:0]                        irq_i,
    output logic [periph_pkg::DATA_W-1:0]                           data_o,
    output logic                                                    irq_o,
    output logic [periph_pkg::TIMER_ID_W-1:0]                       irq_id_o
);
    import periph_pkg::*;

    // read data of the addressed timer, zero when no slot matches
    always_comb begin
        data_o = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (sel_i[i]) begin
                data_o = rd_data_i[i];
            end
        end
    end

    assign irq_o = |irq_i;

    // fixed priority, lowest index wins
    always_comb begin
        irq_id_o = '0;
        for (int i = NUM_TIMERS - 1; i >= 0; i--) begin
            if (irq_i[i]) begin
                irq_id_o = TIMER_ID_W'(i);
            end
        end
    end

    always_comb begin
        irq_id_a: assert final (!irq_o || irq_i[irq_id_o])
            else $error("irq_id_o %0d names an idle interrupt line", irq_id_o);
    end

endmodule

`default_nettype wire

/* rtl/periph_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_timer (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          we_i,
    input  wire [3:0]                    offset_i,
    input  wire [periph_pkg::DATA_W-1:0] data_i,
    output logic [periph_pkg::DATA_W-1:0] rd_data_o,
    output logic                         irq_o
);
    import periph_pkg::*;

    // control bits, the upper control bits are not stored
    logic en_q;
    logic ie_q;
    logic ip_q;

    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] value_q;

    logic              expire;
    logic [DATA_W-1:0] ctrl_word;

    // count has reached the expiry value while running
    assign expire = en_q && (count_q >= value_q);

    // counter, held at zero while disabled
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (!en_q || expire) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // control register
    // a bus write to this timer takes priority over the expiry update
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q <= 1'b0;
            ie_q <= 1'b0;
            ip_q <= 1'b0;
        end else if (we_i) begin
            if (offset_i == REG_CTRL) begin
                en_q <= data_i[CTRL_EN];
                ie_q <= data_i[CTRL_IE];
                ip_q <= ip_q & ~data_i[CTRL_IP];
            end
        end else if (expire) begin
            en_q <= 1'b0;
            ip_q <= 1'b1;
        end
    end

    // expiry value
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            value_q <= '0;
        end else if (we_i && (offset_i == REG_VALUE)) begin
            value_q <= data_i;
        end
    end

    always_comb begin
        ctrl_word          = '0;
        ctrl_word[CTRL_EN] = en_q;
        ctrl_word[CTRL_IE] = ie_q;
        ctrl_word[CTRL_IP] = ip_q;
    end

    // read mux
    always_comb begin
        case (offset_i)
            REG_CTRL:  rd_data_o = ctrl_word;
            REG_COUNT: rd_data_o = count_q;
            REG_VALUE: rd_data_o = value_q;
            default:   rd_data_o = '0;
        endcase
    end

    assign irq_o = ip_q & ie_q;

    // counter restarts from zero whenever the timer was off
    count_idle_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !en_q |=> (count_q == '0)
    ) else $error("count not zero after a cycle with enable low");

    // pending only sets on an expiry edge that no bus write overrides
    ip_set_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (!ip_q && !(expire && !we_i)) |=> !ip_q
    ) else $error("pending set outside an expiry edge");

endmodule

`default_nettype wire

/* rtl/periph_addr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_addr_decode (
    input  wire [periph_pkg::ADDR_W-1:0]     addr_i,
    input  wire                              we_i,
    output logic [periph_pkg::NUM_TIMERS-1:0] sel_o,
    output logic [periph_pkg::NUM_TIMERS-1:0] timer_we_o,
    output logic                             addr_err_o
);
    import periph_pkg::*;

    logic [SLOT_W-1:0]   slot;
    logic [SLOT_LSB-1:0] offset;
    logic                offset_ok;

    assign slot   = addr_i[SLOT_LSB +: SLOT_W];
    assign offset = addr_i[SLOT_LSB-1:0];

    // one select line per mapped slot
    always_comb begin
        sel_o = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (slot == SLOT_W'(i)) begin
                sel_o[i] = 1'b1;
            end
        end
    end

    assign timer_we_o = sel_o & {NUM_TIMERS{we_i}};

    assign offset_ok = (offset == REG_CTRL) || (offset == REG_COUNT) ||
                       (offset == REG_VALUE);

    // unmapped slot or a hole in the register map
    assign addr_err_o = !(|sel_o) || !offset_ok;

    always_comb begin
        sel_onehot_a: assert final ($onehot0(sel_o))
            else $error("timer select is not one-hot: %b", sel_o);
    end

endmodule

`default_nettype wire

/* rtl/periph_pkg.sv */
`default_nettype none

package periph_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // timer instances and the width of a timer index
    localparam int NUM_TIMERS = 2;
    localparam int TIMER_ID_W = 1;

    // timer slot in addr[7:4], only slots below NUM_TIMERS are mapped
    localparam int SLOT_LSB = 4;
    localparam int SLOT_W   = 4;

    // register offsets inside a slot, addr[3:0]
    localparam logic [3:0] REG_CTRL  = 4'h0;
    localparam logic [3:0] REG_COUNT = 4'h4;
    localparam logic [3:0] REG_VALUE = 4'h8;

    // control register bits
    // enable
    localparam int CTRL_EN = 0;
    // interrupt enable
    localparam int CTRL_IE = 1;
    // interrupt pending, write 1 to clear
    localparam int CTRL_IP = 2;

endpackage

`default_nettype wire
